// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_wb
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== list.f ====
verilog/mem_pkg.sv
verilog/ex_mem_reg.sv
verilog/mem_stage.sv
verilog/data_ram.sv
verilog/wb_commit.sv
verilog/mem_wb_top.sv
test/tb_mem_wb.sv

// ==== test/tb_mem_wb.sv ====
`timescale 1ns/1ns

module tb_mem_wb
    import mem_pkg::*;
();

    localparam int RAM_WORDS   = 256;
    localparam int BYTE_AW     = $clog2(RAM_WORDS * 8);
    localparam int RUN_INSTRS  = 2000;
    localparam int CYCLE_LIMIT = 10 * (RUN_INSTRS + RAM_WORDS);

    typedef struct packed {
        pc_t       pc;
        inst_t     inst;
        logic      we;
        reg_addr_t waddr;
        xlen_t     wdata;
    } retire_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       valid;
    logic       ena;
    ex_bundle_t ex_in;
    logic       rf_we;
    reg_addr_t  rf_waddr;
    xlen_t      rf_wdata;
    logic       retire_valid;
    pc_t        retire_pc;
    inst_t      retire_inst;
    logic       halted;

    int         seed = 22269;
    int         cycles = 0;
    logic [7:0] ram_m [RAM_WORDS * 8];  // byte image of the data ram.
    ex_bundle_t mem_m;                  // model of the ex/mem register.
    logic       halted_m;
    retire_t    exp_q [$];

    mem_wb_top #(.RAM_WORDS(RAM_WORDS)) dut0 (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .ena          (ena),
        .ex_in        (ex_in),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst),
        .halted       (halted)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // reporting
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped.");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic int access_bytes(mem_size_e size);
        return 1 << int'(size);
    endfunction

    function automatic ex_bundle_t bubble_bundle();
        ex_bundle_t b;
        b = '0;
        b.pc = RESET_PC;
        return b;
    endfunction

    function automatic xlen_t aligned_addr(mem_size_e size);
        logic [2:0] off;
        off = 3'(rand_below(8));
        case (size)
            SIZE_H:  off[0] = 1'b0;
            SIZE_W:  off[1:0] = 2'b00;
            SIZE_D:  off = 3'b000;
            default: off = off;
        endcase
        return 64'(rand_below(RAM_WORDS)) * 64'd8 + 64'(off);
    endfunction

    function automatic ex_bundle_t fill_store(int w);
        ex_bundle_t b;
        b = bubble_bundle();
        b.live        = 1'b1;
        b.pc          = RESET_PC + 64'(w) * 64'd4;
        b.inst        = 32'h0000_3023;      // sd.
        b.alu_result  = 64'(w) * 64'd8;
        b.mem_ena     = 1'b1;
        b.mem_wen     = 1'b1;
        b.sel_memdata = SIZE_D;
        b.rf_rdata2   = (64'(w) * 64'h9e37_79b9_7f4a_7c15) ^ {32'(w), ~32'(w)};
        return b;
    endfunction

    function automatic ex_bundle_t random_instr();
        ex_bundle_t b;
        int         kind;
        b = '0;
        b.live         = 1'b1;
        b.pc           = RESET_PC + 64'(rand_below(1 << 20)) * 64'd4;
        b.inst         = $random(seed);
        b.alu_result   = {$random(seed), $random(seed)};
        b.rf_rdata2    = {$random(seed), $random(seed)};
        b.csr_data     = {$random(seed), $random(seed)};
        b.sel_memdata  = mem_size_e'(2'(rand_below(4)));
        b.mem_unsigned = rand_below(2) != 0;
        b.rf_we        = rand_below(8) != 0;
        b.rf_waddr     = reg_addr_t'(rand_below(32));
        kind = rand_below(100);
        if (rand_below(250) == 0) begin
            b.ebreak = 1'b1;                // keeps a random write enable.
            b.inst   = 32'h0010_0073;
        end else if (kind < 25) begin
            b.sel_rfres = (rand_below(4) == 0) ? rfres_sel_e'(3'(4 + rand_below(4))) : RES_ALU;
        end else if (kind < 45) begin
            b.alu_result = aligned_addr(b.sel_memdata);
            b.mem_ena    = 1'b1;
            b.mem_wen    = 1'b1;
            b.rf_we      = 1'b0;
        end else if (kind < 70) begin
            b.alu_result = aligned_addr(b.sel_memdata);
            b.mem_ena    = 1'b1;
            b.load       = 1'b1;
            b.sel_rfres  = RES_LOAD;
        end else if (kind < 85) begin
            b.sel_rfres = RES_CSR;
        end else begin
            b.sel_rfres = RES_PC4;
        end
        return b;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~
    function automatic xlen_t expected_result(ex_bundle_t b);
        xlen_t              v;
        logic [BYTE_AW-1:0] addr;
        int                 n;
        v = '0;
        case (b.sel_rfres)
            RES_LOAD: begin
                addr = b.alu_result[BYTE_AW-1:0];
                n = access_bytes(b.sel_memdata);
                for (int i = 0; i < n; i++) begin
                    v = v | (xlen_t'(ram_m[addr + BYTE_AW'(i)]) << (8 * i));
                end
                if (!b.mem_unsigned) begin
                    v = $signed(v << (64 - 8 * n)) >>> (64 - 8 * n);
                end
            end
            RES_CSR: v = b.csr_data;
            RES_PC4: v = b.pc + 64'd4;
            default: v = b.alu_result;     // unused codes read the alu.
        endcase
        return v;
    endfunction

    task automatic apply_store(input ex_bundle_t b);
        logic [BYTE_AW-1:0] addr;
        addr = b.alu_result[BYTE_AW-1:0];
        for (int i = 0; i < access_bytes(b.sel_memdata); i++) begin
            ram_m[addr + BYTE_AW'(i)] = 8'(b.rf_rdata2 >> (8 * i));
        end
    endtask

    // advance the model over the coming rising edge.
    task automatic model_edge();
        retire_t e;
        if (rst) begin
            mem_m = bubble_bundle();
            halted_m = 1'b0;
        end else begin
            if (ena && !halted_m && mem_m.live) begin
                e.pc    = mem_m.pc;
                e.inst  = mem_m.inst;
                e.we    = mem_m.rf_we && (mem_m.rf_waddr != 5'd0) && !mem_m.ebreak;
                e.waddr = mem_m.rf_waddr;
                e.wdata = expected_result(mem_m);
                exp_q.push_back(e);
                if (mem_m.ebreak) begin
                    halted_m = 1'b1;
                end
            end
            if (ena && mem_m.mem_ena && mem_m.mem_wen) begin
                apply_store(mem_m);         // stores land even while halted.
            end
            if (!valid) begin
                mem_m = bubble_bundle();
            end else if (ena) begin
                mem_m = ex_in;
            end
        end
    endtask

    task automatic check_outputs();
        retire_t e;
        check_value(64'(halted), 64'(halted_m), "halted");
        if (retire_valid) begin
            if (exp_q.size() == 0) begin
                abort_run($sformatf("retire_valid at %0t ns with no instruction pending", $time));
            end else begin
                e = exp_q.pop_front();
                check_value(retire_pc, e.pc, "retire_pc");
                check_value(64'(retire_inst), 64'(e.inst), "retire_inst");
                check_value(64'(rf_we), 64'(e.we), "rf_we");
                if (e.we) begin
                    check_value(64'(rf_waddr), 64'(e.waddr), "rf_waddr");
                    check_value(rf_wdata, e.wdata, "rf_wdata");
                end
            end
        end else begin
            check_value(64'(exp_q.size()), 64'd0, "pending retirements");
            check_value(64'(rf_we), 64'd0, "rf_we without retirement");
        end
    endtask

    task automatic run_cycle(input logic n_rst, input logic n_valid, input logic n_ena,
                             input ex_bundle_t n_in);
        @(negedge clk);
        check_outputs();
        rst   = n_rst;
        valid = n_valid;
        ena   = n_ena;
        ex_in = n_in;
        model_edge();
    endtask

    task automatic reset_dut();
        repeat (4) run_cycle(1'b1, 1'b0, 1'b0, bubble_bundle());
    endtask

    // present one instruction until it is captured, with stalls and flushes in between.
    task automatic drive_instr(input ex_bundle_t b);
        logic go_ena;
        logic done;
        done = 1'b0;
        while (!done) begin
            go_ena = rand_below(5) != 0;
            if (!go_ena) begin
                run_cycle(1'b0, 1'b1, 1'b0, b);
            end else if (rand_below(10) == 0) begin
                run_cycle(1'b0, 1'b0, 1'b1, random_instr());   // flushed.
            end else begin
                run_cycle(1'b0, 1'b1, 1'b1, b);
                done = 1'b1;
            end
        end
    endtask

    initial begin
        int halt_wait;
        halt_wait = 0;
        rst      = 1'b1;
        valid    = 1'b0;
        ena      = 1'b0;
        ex_in    = bubble_bundle();
        mem_m    = bubble_bundle();
        halted_m = 1'b0;
        reset_dut();
        for (int w = 0; w < RAM_WORDS; w++) begin
            drive_instr(fill_store(w));
        end
        for (int n = 0; n < RUN_INSTRS; n++) begin
            drive_instr(random_instr());
            if (halted_m) begin
                halt_wait++;
                if (halt_wait == 6) begin
                    reset_dut();
                    halt_wait = 0;
                end
            end
        end
        repeat (4) run_cycle(1'b0, 1'b0, 1'b1, bubble_bundle());
        if (exp_q.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run("instructions were still waiting to retire at the end of the run");
        end
    end

endmodule

// ==== verilog/data_ram.sv ====
`timescale 1ns/1ns

module data_ram
    import mem_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  logic                         clk,
    input  logic [$clog2(RAM_WORDS)-1:0] ram_addr,
    input  xlen_t                        ram_wdata,
    input  logic [7:0]                   ram_wstrb,
    output xlen_t                        ram_rdata
);

    xlen_t mem [RAM_WORDS];

    // ~~~~~~~~~~~~~~~~~~~~
    // byte lane writes
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        for (int i = 0; i < 8; i++) begin
            if (ram_wstrb[i]) begin
                mem[ram_addr][i*8 +: 8] <= ram_wdata[i*8 +: 8];
            end
        end
    end

    assign ram_rdata = mem[ram_addr];       // asynchronous read.

endmodule

// ==== verilog/ex_mem_reg.sv ====
`timescale 1ns/1ns

module ex_mem_reg
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       valid,
    input  logic       ena,
    input  ex_bundle_t ex_in,
    output ex_bundle_t mem_q
);

    // ~~~~~~~~~~~~~~~~~~~~
    // pipeline register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst || !valid) begin
            mem_q    <= '0;                 // clean bubble.
            mem_q.pc <= RESET_PC;
        end else if (ena) begin
            mem_q <= ex_in;
        end                                 // stall holds.
    end

    // a bubble must not reach memory, the register file or the halt latch.
    // upstream is trusted to clear these flags on a dead bundle.
    a_bubble_clean : assert property (
        @(posedge clk) disable iff (rst)
        !mem_q.live |-> !(mem_q.rf_we || mem_q.mem_ena || mem_q.ebreak)
    ) else $error("ex_mem_reg: dead bundle carries side effects.");

endmodule

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~
    typedef logic [63:0] xlen_t;        // register and data word.
    typedef logic [63:0] pc_t;          // program counter.
    typedef logic [31:0] inst_t;        // instruction word.
    typedef logic [4:0]  reg_addr_t;    // register file index.

    localparam pc_t RESET_PC = 64'h0000_0000_8000_0000;   // pc carried by a bubble.

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W,
        SIZE_D
    } mem_size_e;

    // codes above RES_PC4 fall back to the alu result.
    typedef enum logic [2:0] {
        RES_ALU,
        RES_LOAD,
        RES_CSR,
        RES_PC4
    } rfres_sel_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // stage bundles
    // ~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic       live;
        pc_t        pc;
        inst_t      inst;
        xlen_t      alu_result;     // also the memory address.
        rfres_sel_e sel_rfres;
        logic       mem_wen;
        logic       mem_ena;
        logic       mem_unsigned;   // zero extend on load.
        xlen_t      rf_rdata2;      // store data.
        mem_size_e  sel_memdata;
        logic       rf_we;
        reg_addr_t  rf_waddr;
        logic       ebreak;
        logic       load;
        xlen_t      csr_data;
    } ex_bundle_t;

    typedef struct packed {
        logic      live;
        pc_t       pc;
        inst_t     inst;
        logic      rf_we;
        reg_addr_t rf_waddr;
        xlen_t     rf_wdata;
        logic      ebreak;
    } wb_bundle_t;

endpackage

// ==== verilog/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage
    import mem_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         ena,
    input  ex_bundle_t                   mem_q,
    input  xlen_t                        ram_rdata,
    output logic [$clog2(RAM_WORDS)-1:0] ram_addr,
    output xlen_t                        ram_wdata,
    output logic [7:0]                   ram_wstrb,
    output wb_bundle_t                   wb_d
);

    localparam int AW = $clog2(RAM_WORDS);

    logic [2:0] byte_off;
    logic [7:0] size_strb;
    logic       misaligned;
    xlen_t      lane;
    xlen_t      load_data;
    xlen_t      rf_wdata;

    assign byte_off = mem_q.alu_result[2:0];
    assign ram_addr = mem_q.alu_result[AW+2:3];     // doubleword index.

    // ~~~~~~~~~~~~~~~~~~~~
    // store path
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (mem_q.sel_memdata)
            SIZE_B:  size_strb = 8'h01;
            SIZE_H:  size_strb = 8'h03;
            SIZE_W:  size_strb = 8'h0f;
            default: size_strb = 8'hff;
        endcase
    end

    assign ram_wdata = mem_q.rf_rdata2 << {byte_off, 3'b000};   // little endian lanes.
    assign ram_wstrb = (ena && mem_q.mem_ena && mem_q.mem_wen) ?
                       (size_strb << byte_off) : 8'h00;

    // ~~~~~~~~~~~~~~~~~~~~
    // load path
    // ~~~~~~~~~~~~~~~~~~~~
    assign lane = ram_rdata >> {byte_off, 3'b000};

    always_comb begin
        case (mem_q.sel_memdata)
            SIZE_B:  load_data = mem_q.mem_unsigned ? {56'b0, lane[7:0]} :
                                 {{56{lane[7]}}, lane[7:0]};
            SIZE_H:  load_data = mem_q.mem_unsigned ? {48'b0, lane[15:0]} :
                                 {{48{lane[15]}}, lane[15:0]};
            SIZE_W:  load_data = mem_q.mem_unsigned ? {32'b0, lane[31:0]} :
                                 {{32{lane[31]}}, lane[31:0]};
            default: load_data = lane;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // result select
    // ~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (mem_q.sel_rfres)
            RES_LOAD: rf_wdata = load_data;
            RES_CSR:  rf_wdata = mem_q.csr_data;
            RES_PC4:  rf_wdata = mem_q.pc + 64'd4;  // link address.
            default:  rf_wdata = mem_q.alu_result;
        endcase
    end

    assign wb_d.live     = mem_q.live;
    assign wb_d.pc       = mem_q.pc;
    assign wb_d.inst     = mem_q.inst;
    assign wb_d.rf_we    = mem_q.rf_we;
    assign wb_d.rf_waddr = mem_q.rf_waddr;
    assign wb_d.rf_wdata = rf_wdata;
    assign wb_d.ebreak   = mem_q.ebreak;

    always_comb begin
        case (mem_q.sel_memdata)
            SIZE_B:  misaligned = 1'b0;
            SIZE_H:  misaligned = byte_off[0];
            SIZE_W:  misaligned = |byte_off[1:0];
            default: misaligned = |byte_off;
        endcase
    end

    // execute is expected to trap misaligned accesses before they get here.
    a_aligned : assert property (
        @(posedge clk) (mem_q.live && (mem_q.mem_ena || mem_q.load)) |-> !misaligned
    ) else $error("mem_stage: misaligned access at pc %h.", mem_q.pc);

endmodule

// ==== verilog/mem_wb_top.sv ====
`timescale 1ns/1ns

module mem_wb_top
    import mem_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       valid,
    input  logic       ena,
    input  ex_bundle_t ex_in,
    output logic       rf_we,
    output reg_addr_t  rf_waddr,
    output xlen_t      rf_wdata,
    output logic       retire_valid,
    output pc_t        retire_pc,
    output inst_t      retire_inst,
    output logic       halted
);

    ex_bundle_t                   mem_q;
    wb_bundle_t                   wb_d;
    logic [$clog2(RAM_WORDS)-1:0] ram_addr;
    xlen_t                        ram_wdata;
    xlen_t                        ram_rdata;
    logic [7:0]                   ram_wstrb;

    ex_mem_reg u_ex_mem_reg (
        .clk   (clk),
        .rst   (rst),
        .valid (valid),
        .ena   (ena),
        .ex_in (ex_in),
        .mem_q (mem_q)
    );

    mem_stage #(.RAM_WORDS(RAM_WORDS)) u_mem_stage (
        .clk       (clk),
        .ena       (ena),
        .mem_q     (mem_q),
        .ram_rdata (ram_rdata),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_wstrb (ram_wstrb),
        .wb_d      (wb_d)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) u_data_ram (
        .clk       (clk),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_wstrb (ram_wstrb),
        .ram_rdata (ram_rdata)
    );

    wb_commit u_wb_commit (
        .clk          (clk),
        .rst          (rst),
        .ena          (ena),
        .wb_d         (wb_d),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst),
        .halted       (halted)
    );

endmodule

// ==== verilog/wb_commit.sv ====
`timescale 1ns/1ns

module wb_commit
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ena,
    input  wb_bundle_t wb_d,
    output logic       rf_we,
    output reg_addr_t  rf_waddr,
    output xlen_t      rf_wdata,
    output logic       retire_valid,
    output pc_t        retire_pc,
    output inst_t      retire_inst,
    output logic       halted
);

    wb_bundle_t wb_q;

    // ~~~~~~~~~~~~~~~~~~~~
    // mem/wb register
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst || !ena || halted) begin
            wb_q    <= '0;                  // one commit per ena edge.
            wb_q.pc <= RESET_PC;
        end else begin
            wb_q <= wb_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (ena && !halted && wb_d.live && wb_d.ebreak) begin
            halted <= 1'b1;                 // sticky until reset.
        end
    end

    assign rf_we        = wb_q.rf_we && (wb_q.rf_waddr != 5'd0) && !halted;   // x0 is hardwired.
    assign rf_waddr     = wb_q.rf_waddr;
    assign rf_wdata     = wb_q.rf_wdata;
    assign retire_valid = wb_q.live;        // the ebreak itself still retires.
    assign retire_pc    = wb_q.pc;
    assign retire_inst  = wb_q.inst;

    // a register write always belongs to a retiring instruction.
    a_we_retires : assert property (
        @(posedge clk) disable iff (rst)
        rf_we |-> retire_valid
    ) else $error("wb_commit: register write without retirement.");

endmodule
